// File: include/host_monitor_consts.svh
`ifndef HOST_MONITOR_CONSTS_SVH
`define HOST_MONITOR_CONSTS_SVH

// Data path widths
`define HM_ADDR_W 32
`define HM_CNT_W 16
`define HM_CFG_ADDR_W 4

// Counter layout, region * 4 + type for the access counters
`define HM_NUM_ACC_CNT 8
`define HM_DMA_CNT_IDX 8

// Configuration register map
`define HM_THRESH_ADDR 4'd9
`define HM_IRQ_ADDR 4'd10
`define HM_UNMAPPED_RDATA 16'hDEAD

// Address rules, upper bound exclusive
`define HM_DBG_BASE 32'h0000_0000
`define HM_DBG_END 32'h1000_0000
`define HM_HYP_BASE 32'h8000_0000
`define HM_HYP_END 32'hC000_0000

`endif

// File: verilog/host_monitor_pkg.sv
`include "host_monitor_consts.svh"

package host_monitor_pkg;

  // Memory access address
  typedef logic [`HM_ADDR_W-1:0] addr_t;

  // Counter value and configuration word
  typedef logic [`HM_CNT_W-1:0] cnt_t;

  typedef logic [`HM_CFG_ADDR_W-1:0] cfg_addr_t;

  // One-hot access event
  // bit = region * 4 + type
  // type 0 read hit, 1 read miss, 2 write hit, 3 write miss
  // region 0 debug, 1 HyperRAM
  typedef logic [`HM_NUM_ACC_CNT-1:0] acc_event_t;

  // Access seen at the last-level cache
  typedef struct packed {
    addr_t addr;
    logic  write;
    logic  hit;
  } mem_access_t;

  // Configuration port request, read and write are one-cycle strobes
  typedef struct packed {
    logic      write;
    logic      read;
    cfg_addr_t addr;
    cnt_t      wdata;
  } cfg_req_t;

endpackage

// File: verilog/region_classifier.sv
`include "host_monitor_consts.svh"

module region_classifier (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          acc_valid_i,
  input  host_monitor_pkg::mem_access_t acc_i,
  output host_monitor_pkg::acc_event_t  event_o
);

  logic                         dbg_match;
  logic                         hyp_match;
  logic [1:0]                   acc_type;
  host_monitor_pkg::acc_event_t event_d;
  host_monitor_pkg::acc_event_t event_q;

  // Lower bound inclusive, upper bound exclusive
  function automatic logic in_rule(
    input host_monitor_pkg::addr_t addr,
    input host_monitor_pkg::addr_t lo,
    input host_monitor_pkg::addr_t hi
  );
    return (addr >= lo) && (addr < hi);
  endfunction

  assign dbg_match = in_rule(acc_i.addr, `HM_DBG_BASE, `HM_DBG_END);
  assign hyp_match = in_rule(acc_i.addr, `HM_HYP_BASE, `HM_HYP_END);

  // Write in the upper bit, miss in the lower
  assign acc_type = {acc_i.write, ~acc_i.hit};

  always_comb begin
    event_d = '0;
    if (acc_valid_i) begin
      if (dbg_match) begin
        event_d[{1'b0, acc_type}] = 1'b1;
      end else if (hyp_match) begin
        event_d[{1'b1, acc_type}] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      event_q <= '0;
    end else begin
      event_q <= event_d;
    end
  end

  assign event_o = event_q;

endmodule

// File: verilog/dma_event_receiver.sv
module dma_event_receiver (
  input  logic clk_i,
  input  logic reset_i,
  input  logic evt_valid_i,
  output logic evt_pulse_o,
  output logic evt_ack_o
);

  logic sync_q1;
  logic sync_q2;
  logic level_q;
  logic pulse_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      level_q <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      // Toggle input comes from the cluster clock domain
      sync_q1 <= evt_valid_i;
      sync_q2 <= sync_q1;
      level_q <= sync_q2;
      // One pulse for every change of the synchronized level
      pulse_q <= sync_q2 ^ level_q;
    end
  end

  // Sender sees its own level once it has crossed over
  assign evt_ack_o   = sync_q2;
  assign evt_pulse_o = pulse_q;

endmodule

// File: verilog/event_counter_bank.sv
`include "host_monitor_consts.svh"

module event_counter_bank (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  host_monitor_pkg::acc_event_t  event_i,
  input  logic                          dma_pulse_i,
  input  host_monitor_pkg::cfg_req_t    cfg_i,
  output logic                          cfg_rvalid_o,
  output host_monitor_pkg::cnt_t        cfg_rdata_o,
  output logic                          irq_o
);

  // Access counters plus the DMA counter on top
  localparam int NumCnt = `HM_DMA_CNT_IDX + 1;

  host_monitor_pkg::cnt_t cnt_q   [NumCnt];
  host_monitor_pkg::cnt_t cnt_inc [NumCnt];
  host_monitor_pkg::cnt_t thresh_q;
  host_monitor_pkg::cnt_t rdata_d;
  host_monitor_pkg::cnt_t rdata_q;

  logic [NumCnt-1:0] inc;
  logic [NumCnt-1:0] wr_sel;
  logic [NumCnt-1:0] thresh_hit;
  logic              thresh_wr;
  logic              irq_clr;
  logic              irq_set;
  logic              irq_q;
  logic              rvalid_q;

  assign inc = {dma_pulse_i, event_i};

  always_comb begin
    for (int i = 0; i < NumCnt; i++) begin
      cnt_inc[i] = cnt_q[i] + 1'b1;
      wr_sel[i]  = cfg_i.write && (cfg_i.addr == host_monitor_pkg::cfg_addr_t'(i));
      // A write to the same counter suppresses the increment
      thresh_hit[i] = inc[i] && !wr_sel[i] && (thresh_q != '0) &&
                      (cnt_inc[i] == thresh_q);
    end
  end

  assign thresh_wr = cfg_i.write && (cfg_i.addr == `HM_THRESH_ADDR);
  assign irq_clr   = cfg_i.write && (cfg_i.addr == `HM_IRQ_ADDR);
  assign irq_set   = |thresh_hit;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NumCnt; i++) begin
        cnt_q[i] <= '0;
      end
      thresh_q <= '0;
      irq_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      for (int i = 0; i < NumCnt; i++) begin
        if (wr_sel[i]) begin
          cnt_q[i] <= cfg_i.wdata;
        end else if (inc[i]) begin
          cnt_q[i] <= cnt_inc[i];
        end
      end
      if (thresh_wr) begin
        thresh_q <= cfg_i.wdata;
      end
      // Set wins over a clear in the same cycle
      if (irq_set) begin
        irq_q <= 1'b1;
      end else if (irq_clr) begin
        irq_q <= 1'b0;
      end
      rvalid_q <= cfg_i.read;
    end
  end

  // Read mux, unmapped addresses fall through to the default
  always_comb begin
    rdata_d = `HM_UNMAPPED_RDATA;
    for (int i = 0; i < NumCnt; i++) begin
      if (cfg_i.addr == host_monitor_pkg::cfg_addr_t'(i)) begin
        rdata_d = cnt_q[i];
      end
    end
    if (cfg_i.addr == `HM_THRESH_ADDR) begin
      rdata_d = thresh_q;
    end
    if (cfg_i.addr == `HM_IRQ_ADDR) begin
      rdata_d = host_monitor_pkg::cnt_t'(irq_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_i.read) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_rvalid_o = rvalid_q;
  assign cfg_rdata_o  = rdata_q;
  assign irq_o        = irq_q;

endmodule

// File: verilog/host_monitor_top.sv
module host_monitor_top (
  input  logic                          clk_i,
  input  logic                          reset_i,

  // LLC access strobe
  input  logic                          acc_valid_i,
  input  host_monitor_pkg::mem_access_t acc_i,

  // Cluster DMA event, toggle style
  input  logic                          dma_evt_valid_i,
  output logic                          dma_evt_ack_o,

  // Configuration port
  input  host_monitor_pkg::cfg_req_t    cfg_i,
  output logic                          cfg_rvalid_o,
  output host_monitor_pkg::cnt_t        cfg_rdata_o,

  output logic                          irq_o
);

  host_monitor_pkg::acc_event_t acc_event;
  logic                         dma_pulse;

  region_classifier u_region_classifier (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .acc_valid_i ( acc_valid_i ),
    .acc_i       ( acc_i       ),
    .event_o     ( acc_event   )
  );

  dma_event_receiver u_dma_event_receiver (
    .clk_i       ( clk_i           ),
    .reset_i     ( reset_i         ),
    .evt_valid_i ( dma_evt_valid_i ),
    .evt_pulse_o ( dma_pulse       ),
    .evt_ack_o   ( dma_evt_ack_o   )
  );

  // Both event sources meet in the counter bank
  event_counter_bank u_event_counter_bank (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .event_i      ( acc_event    ),
    .dma_pulse_i  ( dma_pulse    ),
    .cfg_i        ( cfg_i        ),
    .cfg_rvalid_o ( cfg_rvalid_o ),
    .cfg_rdata_o  ( cfg_rdata_o  ),
    .irq_o        ( irq_o        )
  );

endmodule

// File: tests/tb_host_monitor.sv
`include "host_monitor_consts.svh"

module tb_host_monitor;

  localparam int ClkPeriod   = 40;
  localparam int DriveDelay  = 5;
  localparam int NumAccesses = 300;
  localparam int NumToggles  = 20;
  localparam int NumCfgRegs  = 1 << `HM_CFG_ADDR_W;
  // Burst takes at most 4 cycles per access, toggles at most 12, reads 2 each
  localparam int WatchdogCycles = 5000;

  logic                          clk_i;
  logic                          reset_i;
  logic                          acc_valid_i;
  host_monitor_pkg::mem_access_t acc_i;
  logic                          dma_evt_valid_i;
  logic                          dma_evt_ack_o;
  host_monitor_pkg::cfg_req_t    cfg_i;
  logic                          cfg_rvalid_o;
  host_monitor_pkg::cnt_t        cfg_rdata_o;
  logic                          irq_o;

  // Reference model of the register file
  host_monitor_pkg::cnt_t model_cnt [`HM_DMA_CNT_IDX+1];
  host_monitor_pkg::cnt_t model_thresh;
  logic                   model_irq;

  int seed;
  int checks;
  int errors;

  host_monitor_top u_host_monitor_top (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .acc_valid_i     ( acc_valid_i     ),
    .acc_i           ( acc_i           ),
    .dma_evt_valid_i ( dma_evt_valid_i ),
    .dma_evt_ack_o   ( dma_evt_ack_o   ),
    .cfg_i           ( cfg_i           ),
    .cfg_rvalid_o    ( cfg_rvalid_o    ),
    .cfg_rdata_o     ( cfg_rdata_o     ),
    .irq_o           ( irq_o           )
  );

  always #(ClkPeriod/2) clk_i = ~clk_i;

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic check_value(input host_monitor_pkg::cnt_t actual,
                             input host_monitor_pkg::cnt_t expected, input string what);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail at %0t: %s, got 0x%h, expected 0x%h", $time, what, actual, expected);
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail at %0t: %s, got %b, expected %b", $time, what, actual, expected);
    end
  endtask

  // Data is sampled in the single cycle where cfg_rvalid_o must be high
  task automatic read_reg(input host_monitor_pkg::cfg_addr_t addr,
                          output host_monitor_pkg::cnt_t data);
    cfg_i.read  = 1'b1;
    cfg_i.write = 1'b0;
    cfg_i.addr  = addr;
    next_cycle();
    cfg_i.read = 1'b0;
    data = cfg_rdata_o;
    checks++;
    assert (cfg_rvalid_o === 1'b1) else begin
      errors++;
      $display("No cfg_rvalid_o in the cycle after the read of address %0d at time %0t",
               addr, $time);
    end
    next_cycle();
    checks++;
    assert (cfg_rvalid_o === 1'b0) else begin
      errors++;
      $display("cfg_rvalid_o stayed high longer than one cycle after the read of address %0d",
               addr);
    end
  endtask

  task automatic write_reg(input host_monitor_pkg::cfg_addr_t addr,
                           input host_monitor_pkg::cnt_t data);
    cfg_i.write = 1'b1;
    cfg_i.read  = 1'b0;
    cfg_i.addr  = addr;
    cfg_i.wdata = data;
    next_cycle();
    cfg_i.write = 1'b0;
  endtask

  // Counter index for an access, -1 outside both regions
  function automatic int expected_index(input host_monitor_pkg::mem_access_t acc);
    int region;
    int kind;
    if (acc.addr - `HM_DBG_BASE < `HM_DBG_END - `HM_DBG_BASE) begin
      region = 0;
    end else if (acc.addr - `HM_HYP_BASE < `HM_HYP_END - `HM_HYP_BASE) begin
      region = 1;
    end else begin
      return -1;
    end
    kind = (acc.write ? 2 : 0) + (acc.hit ? 0 : 1);
    return region * 4 + kind;
  endfunction

  function automatic void count_event(input int idx);
    model_cnt[idx] = model_cnt[idx] + 16'd1;
    if (model_thresh != 16'd0 && model_cnt[idx] == model_thresh) begin
      model_irq = 1'b1;
    end
  endfunction

  function automatic host_monitor_pkg::cnt_t expected_reg(input int a);
    if (a <= `HM_DMA_CNT_IDX) begin
      return model_cnt[a];
    end
    if (a == int'(`HM_THRESH_ADDR)) begin
      return model_thresh;
    end
    if (a == int'(`HM_IRQ_ADDR)) begin
      return {15'd0, model_irq};
    end
    return `HM_UNMAPPED_RDATA;
  endfunction

  // Mostly inside the regions, some outside, a few right at the bounds
  function automatic host_monitor_pkg::mem_access_t random_access();
    host_monitor_pkg::mem_access_t acc;
    logic [31:0] r;
    logic [31:0] pick;
    r    = rand32();
    pick = rand32();
    case (pick[2:0])
      3'd0, 3'd1, 3'd2: acc.addr = {4'h0, r[27:0]};
      3'd3, 3'd4, 3'd5: acc.addr = {2'b10, r[29:0]};
      3'd6: acc.addr = {2'b01, r[29:0]};
      default: begin
        case (r[2:0])
          3'd0: acc.addr = `HM_DBG_END - 32'd1;
          3'd1: acc.addr = `HM_DBG_END;
          3'd2: acc.addr = `HM_HYP_BASE - 32'd1;
          3'd3: acc.addr = `HM_HYP_BASE;
          3'd4: acc.addr = `HM_HYP_END - 32'd1;
          default: acc.addr = `HM_HYP_END;
        endcase
      end
    endcase
    acc.write = pick[3];
    acc.hit   = pick[4];
    return acc;
  endfunction

  task automatic check_all_registers(input string what);
    host_monitor_pkg::cnt_t data;
    for (int a = 0; a < NumCfgRegs; a++) begin
      read_reg(host_monitor_pkg::cfg_addr_t'(a), data);
      check_value(data, expected_reg(a), $sformatf("%s, register %0d", what, a));
    end
  endtask

  task automatic run_access_burst();
    host_monitor_pkg::mem_access_t acc;
    host_monitor_pkg::cnt_t data;
    logic [31:0] gap;
    int idx;
    int outside;
    outside = 0;
    for (int n = 0; n < NumAccesses; n++) begin
      acc = random_access();
      idx = expected_index(acc);
      if (idx < 0) begin
        outside++;
      end else begin
        count_event(idx);
      end
      acc_valid_i = 1'b1;
      acc_i       = acc;
      next_cycle();
      // Junk on the bus while the strobe is low
      acc_valid_i = 1'b0;
      acc_i       = random_access();
      gap = rand32();
      idle(int'(gap[1:0]));
    end
    idle(4);
    for (int a = 0; a < `HM_NUM_ACC_CNT; a++) begin
      read_reg(host_monitor_pkg::cfg_addr_t'(a), data);
      check_value(data, model_cnt[a], $sformatf("access counter %0d after burst", a));
    end
    $display("Access burst done, %0d of %0d accesses outside both regions",
             outside, NumAccesses);
  endtask

  task automatic run_dma_toggles();
    host_monitor_pkg::cnt_t data;
    logic [31:0] gap;
    for (int n = 0; n < NumToggles; n++) begin
      dma_evt_valid_i = ~dma_evt_valid_i;
      count_event(`HM_DMA_CNT_IDX);
      idle(2);
      check_bit(dma_evt_ack_o, dma_evt_valid_i, "dma_evt_ack_o two cycles after toggle");
      gap = rand32();
      idle(2 + int'(gap[2:0]));
    end
    idle(4);
    read_reg(host_monitor_pkg::cfg_addr_t'(`HM_DMA_CNT_IDX), data);
    check_value(data, model_cnt[`HM_DMA_CNT_IDX], "DMA event counter");
  endtask

  task automatic check_register_access();
    host_monitor_pkg::cnt_t data;
    logic [31:0] r;
    int idx;
    r   = rand32();
    idx = int'(r[3:0]) % (`HM_DMA_CNT_IDX + 1);
    write_reg(host_monitor_pkg::cfg_addr_t'(idx), r[31:16]);
    model_cnt[idx] = r[31:16];
    read_reg(host_monitor_pkg::cfg_addr_t'(idx), data);
    check_value(data, model_cnt[idx], $sformatf("counter %0d read back", idx));
    r = rand32();
    write_reg(`HM_THRESH_ADDR, r[15:0]);
    model_thresh = r[15:0];
    read_reg(`HM_THRESH_ADDR, data);
    check_value(data, model_thresh, "threshold read back");
    r   = rand32();
    idx = int'(`HM_IRQ_ADDR) + 1 + int'(r[2:0]) % (NumCfgRegs - 1 - int'(`HM_IRQ_ADDR));
    write_reg(host_monitor_pkg::cfg_addr_t'(idx), r[31:16]);
    idle(3);
    check_all_registers($sformatf("after write to unmapped address %0d", idx));
  endtask

  task automatic check_threshold_irq();
    host_monitor_pkg::cnt_t data;
    host_monitor_pkg::mem_access_t acc;
    logic [31:0] r;
    logic irq_before;
    // Keep the threshold away from the wrap to zero
    if (model_cnt[0] > 16'hFFF0) begin
      write_reg(host_monitor_pkg::cfg_addr_t'(0), 16'd0);
      model_cnt[0] = 16'd0;
    end
    model_thresh = model_cnt[0] + 16'd3;
    write_reg(`HM_THRESH_ADDR, model_thresh);
    idle(1);
    for (int k = 0; k < 3; k++) begin
      r = rand32();
      acc.addr   = `HM_DBG_BASE | {4'h0, r[27:0]};
      acc.write  = 1'b0;
      acc.hit    = 1'b1;
      irq_before = model_irq;
      count_event(0);
      acc_valid_i = 1'b1;
      acc_i       = acc;
      next_cycle();
      acc_valid_i = 1'b0;
      check_bit(irq_o, irq_before, $sformatf("irq_o while hit %0d is in flight", k + 1));
      next_cycle();
      check_bit(irq_o, model_irq, $sformatf("irq_o after hit %0d is counted", k + 1));
    end
    idle(3);
    check_bit(irq_o, model_irq, "irq_o holds after the threshold hit");
    read_reg(`HM_IRQ_ADDR, data);
    check_value(data, {15'd0, model_irq}, "interrupt flag after threshold hit");
    r = rand32();
    write_reg(`HM_IRQ_ADDR, r[15:0]);
    model_irq = 1'b0;
    check_bit(irq_o, model_irq, "irq_o after clear");
    read_reg(`HM_IRQ_ADDR, data);
    check_value(data, {15'd0, model_irq}, "interrupt flag after clear");
    read_reg(host_monitor_pkg::cfg_addr_t'(0), data);
    check_value(data, model_cnt[0], "debug read hit counter");
  endtask

  initial begin
    seed   = 32'hd224;
    checks = 0;
    errors = 0;
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    acc_valid_i     = 1'b0;
    acc_i           = '0;
    dma_evt_valid_i = 1'b0;
    cfg_i           = '0;
    for (int i = 0; i <= `HM_DMA_CNT_IDX; i++) begin
      model_cnt[i] = 16'd0;
    end
    model_thresh = 16'd0;
    model_irq    = 1'b0;

    repeat (4) @(posedge clk_i);
    #DriveDelay;
    reset_i = 1'b0;

    check_all_registers("after reset");
    check_bit(irq_o, 1'b0, "irq_o after reset");
    run_access_burst();
    run_dma_toggles();
    check_register_access();
    check_threshold_irq();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
verilog/host_monitor_pkg.sv
verilog/region_classifier.sv
verilog/dma_event_receiver.sv
verilog/event_counter_bank.sv
verilog/host_monitor_top.sv
tests/tb_host_monitor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the host monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_host_monitor

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG_FILE"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
